// File: design/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W  = 30;   // application address
    localparam int DATA_W  = 64;   // one beat
    localparam int LEN_W   = 8;    // burst length, 1 to 255 beats
    localparam int N_WR_CH = 3;
    localparam int N_RD_CH = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [LEN_W-1:0]  len_t;

    typedef logic [1:0] wr_ch_t;
    typedef logic [1:0] rd_ch_t;

    // byte address advance per beat
    localparam addr_t ADDR_STEP = addr_t'(8);

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////
    // same codes as the controller core expects on app_cmd
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } burst_state_e;

endpackage

// File: design/wr_arbiter.sv
`timescale 1ns/1ps

module wr_arbiter (
    input  logic                 clk_250m_i,
    input  logic                 rst_i,
    // write channels
    input  logic                 ch_req_i      [mem_ctrl_pkg::N_WR_CH],
    input  mem_ctrl_pkg::addr_t  ch_addr_i     [mem_ctrl_pkg::N_WR_CH],
    input  mem_ctrl_pkg::len_t   ch_len_i      [mem_ctrl_pkg::N_WR_CH],
    input  mem_ctrl_pkg::data_t  ch_data_i     [mem_ctrl_pkg::N_WR_CH],
    output logic                 ch_data_req_o [mem_ctrl_pkg::N_WR_CH],
    output logic                 ch_finish_o   [mem_ctrl_pkg::N_WR_CH],
    // toward the burst engine
    output logic                 wr_req_o,
    output mem_ctrl_pkg::addr_t  wr_addr_o,
    output mem_ctrl_pkg::len_t   wr_len_o,
    output mem_ctrl_pkg::data_t  wr_data_o,
    input  logic                 wr_data_req_i,
    input  logic                 wr_finish_i
);

    import mem_ctrl_pkg::*;

    logic   busy_q;     // a grant is held
    logic   wait_q;     // gap cycle after finish
    wr_ch_t grant_q;    // granted channel, also the round-robin pointer
    logic   sel_vld;
    wr_ch_t sel_ch;

    ////////////////////////////////////////////////////////////
    // round-robin pick, searching from the channel after grant_q
    ////////////////////////////////////////////////////////////
    always_comb begin
        sel_vld = 1'b0;
        sel_ch  = grant_q;
        for (int i = 1; i <= N_WR_CH; i++) begin
            if (!sel_vld && ch_req_i[(int'(grant_q) + i) % N_WR_CH]) begin
                sel_vld = 1'b1;
                sel_ch  = wr_ch_t'((int'(grant_q) + i) % N_WR_CH);
            end
        end
    end

    always_ff @(posedge clk_250m_i) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            wait_q  <= 1'b0;
            grant_q <= wr_ch_t'(N_WR_CH - 1);   // channel 0 goes first
        end else begin
            wait_q <= 1'b0;
            if (busy_q) begin
                if (wr_finish_i) begin
                    busy_q <= 1'b0;
                    wait_q <= 1'b1;   // let the channel drop its req
                end
            end else if (!wait_q && sel_vld) begin
                busy_q  <= 1'b1;
                grant_q <= sel_ch;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // request mux and return steering
    ////////////////////////////////////////////////////////////
    assign wr_req_o  = busy_q && ch_req_i[grant_q];
    assign wr_addr_o = ch_addr_i[grant_q];
    assign wr_len_o  = ch_len_i[grant_q];
    assign wr_data_o = ch_data_i[grant_q];

    always_comb begin
        for (int i = 0; i < N_WR_CH; i++) begin
            ch_data_req_o[i] = busy_q && (grant_q == wr_ch_t'(i)) && wr_data_req_i;
            ch_finish_o[i]   = busy_q && (grant_q == wr_ch_t'(i)) && wr_finish_i;
        end
    end

endmodule

// File: design/rd_arbiter.sv
`timescale 1ns/1ps

module rd_arbiter (
    input  logic                 clk_250m_i,
    input  logic                 rst_i,
    // read channels
    input  logic                 ch_req_i        [mem_ctrl_pkg::N_RD_CH],
    input  mem_ctrl_pkg::addr_t  ch_addr_i       [mem_ctrl_pkg::N_RD_CH],
    input  mem_ctrl_pkg::len_t   ch_len_i        [mem_ctrl_pkg::N_RD_CH],
    output logic                 ch_data_valid_o [mem_ctrl_pkg::N_RD_CH],
    output mem_ctrl_pkg::data_t  ch_data_o       [mem_ctrl_pkg::N_RD_CH],
    output logic                 ch_finish_o     [mem_ctrl_pkg::N_RD_CH],
    // toward the burst engine
    output logic                 rd_req_o,
    output mem_ctrl_pkg::addr_t  rd_addr_o,
    output mem_ctrl_pkg::len_t   rd_len_o,
    input  logic                 rd_data_valid_i,
    input  mem_ctrl_pkg::data_t  rd_data_i,
    input  logic                 rd_finish_i
);

    import mem_ctrl_pkg::*;

    logic   busy_q;
    logic   wait_q;
    rd_ch_t grant_q;    // doubles as the round-robin pointer
    logic   sel_vld;
    rd_ch_t sel_ch;

    ////////////////////////////////////////////////////////////
    // grant, same scheme as the write side
    ////////////////////////////////////////////////////////////
    always_comb begin
        sel_vld = 1'b0;
        sel_ch  = grant_q;
        for (int i = 1; i <= N_RD_CH; i++) begin
            if (!sel_vld && ch_req_i[(int'(grant_q) + i) % N_RD_CH]) begin
                sel_vld = 1'b1;
                sel_ch  = rd_ch_t'((int'(grant_q) + i) % N_RD_CH);
            end
        end
    end

    always_ff @(posedge clk_250m_i) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            wait_q  <= 1'b0;
            grant_q <= rd_ch_t'(N_RD_CH - 1);
        end else begin
            wait_q <= 1'b0;
            if (busy_q) begin
                if (rd_finish_i) begin
                    busy_q <= 1'b0;
                    wait_q <= 1'b1;
                end
            end else if (!wait_q && sel_vld) begin
                busy_q  <= 1'b1;
                grant_q <= sel_ch;
            end
        end
    end

    assign rd_req_o  = busy_q && ch_req_i[grant_q];
    assign rd_addr_o = ch_addr_i[grant_q];
    assign rd_len_o  = ch_len_i[grant_q];

    ////////////////////////////////////////////////////////////
    // read return, one register stage to the owning channel
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_250m_i) begin
        if (rst_i) begin
            for (int i = 0; i < N_RD_CH; i++) begin
                ch_data_valid_o[i] <= 1'b0;
                ch_finish_o[i]     <= 1'b0;
            end
        end else begin
            for (int i = 0; i < N_RD_CH; i++) begin
                ch_data_valid_o[i] <= busy_q && (grant_q == rd_ch_t'(i)) && rd_data_valid_i;
                ch_finish_o[i]     <= busy_q && (grant_q == rd_ch_t'(i)) && rd_finish_i;
            end
        end
    end

    // only the owner's bus moves, the others keep their last word
    always_ff @(posedge clk_250m_i) begin
        for (int i = 0; i < N_RD_CH; i++) begin
            if (rd_data_valid_i && grant_q == rd_ch_t'(i)) begin
                ch_data_o[i] <= rd_data_i;
            end
        end
    end

endmodule

// File: design/burst_engine.sv
`timescale 1ns/1ps

module burst_engine (
    input  logic                   clk_250m_i,
    input  logic                   rst_i,
    input  logic                   init_calib_complete_i,
    // write burst from wr_arbiter
    input  logic                   wr_req_i,
    input  mem_ctrl_pkg::addr_t    wr_addr_i,
    input  mem_ctrl_pkg::len_t     wr_len_i,
    input  mem_ctrl_pkg::data_t    wr_data_i,
    output logic                   wr_data_req_o,
    output logic                   wr_finish_o,
    // read burst from rd_arbiter
    input  logic                   rd_req_i,
    input  mem_ctrl_pkg::addr_t    rd_addr_i,
    input  mem_ctrl_pkg::len_t     rd_len_i,
    output logic                   rd_data_valid_o,
    output mem_ctrl_pkg::data_t    rd_data_o,
    output logic                   rd_finish_o,
    // application port
    output logic                   app_en_o,
    output mem_ctrl_pkg::app_cmd_e app_cmd_o,
    output mem_ctrl_pkg::addr_t    app_addr_o,
    input  logic                   app_rdy_i,
    output logic                   app_wdf_wren_o,
    output mem_ctrl_pkg::data_t    app_wdf_data_o,
    input  logic                   app_wdf_rdy_i,
    input  logic                   app_rd_data_valid_i,
    input  mem_ctrl_pkg::data_t    app_rd_data_i
);

    import mem_ctrl_pkg::*;

    burst_state_e state_q;
    logic         last_wr_q;    // last burst served was a write
    logic         data_req_q;   // beat request to the channel
    logic         fetch_q;      // channel data due this cycle
    logic         wr_fin_q;
    len_t         len_q;
    len_t         beat_cnt_q;   // write beats started / read commands placed
    len_t         ret_cnt_q;    // read beats returned
    addr_t        cur_addr_q;   // next address to place
    logic         can_start;
    logic         start_wr;
    logic         start_rd;
    logic         beat_done;
    logic         rd_issue;

    ////////////////////////////////////////////////////////////
    // burst choice, alternating when both sides wait
    ////////////////////////////////////////////////////////////
    assign can_start = (state_q == ST_IDLE) && init_calib_complete_i;
    assign start_wr  = can_start && wr_req_i && !(rd_req_i && last_wr_q);
    assign start_rd  = can_start && rd_req_i && !start_wr;

    // write beat complete once command and data both got through
    assign beat_done = (state_q == ST_WRITE) && (app_en_o || app_wdf_wren_o)
                       && !(app_en_o && !app_rdy_i)
                       && !(app_wdf_wren_o && !app_wdf_rdy_i);

    // read command accepted with more left to place
    assign rd_issue  = (state_q == ST_READ) && app_en_o && app_rdy_i
                       && (beat_cnt_q != len_q);

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_250m_i) begin
        if (rst_i) begin
            state_q        <= ST_IDLE;
            last_wr_q      <= 1'b0;
            data_req_q     <= 1'b0;
            fetch_q        <= 1'b0;
            wr_fin_q       <= 1'b0;
            app_en_o       <= 1'b0;
            app_wdf_wren_o <= 1'b0;
            beat_cnt_q     <= '0;
            ret_cnt_q      <= '0;
        end else begin
            data_req_q <= 1'b0;         // single-cycle pulses
            fetch_q    <= data_req_q;
            wr_fin_q   <= 1'b0;
            if (app_en_o && app_rdy_i) begin
                app_en_o <= 1'b0;
            end
            if (app_wdf_wren_o && app_wdf_rdy_i) begin
                app_wdf_wren_o <= 1'b0;
            end

            case (state_q)
                ST_IDLE: begin
                    if (start_wr) begin
                        state_q    <= ST_WRITE;
                        last_wr_q  <= 1'b1;
                        data_req_q <= 1'b1;   // beat 0 requested at once
                        beat_cnt_q <= '0;
                    end else if (start_rd) begin
                        state_q    <= ST_READ;
                        last_wr_q  <= 1'b0;
                        app_en_o   <= 1'b1;   // first read command
                        beat_cnt_q <= len_t'(1);
                        ret_cnt_q  <= '0;
                    end
                end
                ST_WRITE: begin
                    if (fetch_q) begin
                        app_en_o       <= 1'b1;
                        app_wdf_wren_o <= 1'b1;
                    end
                    if (beat_done) begin
                        if (beat_cnt_q == len_q - len_t'(1)) begin
                            wr_fin_q <= 1'b1;
                        end else begin
                            data_req_q <= 1'b1;
                            beat_cnt_q <= beat_cnt_q + len_t'(1);
                        end
                    end
                    if (wr_fin_q) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (rd_issue) begin
                        app_en_o   <= 1'b1;   // back to back commands
                        beat_cnt_q <= beat_cnt_q + len_t'(1);
                    end
                    if (app_rd_data_valid_i) begin
                        ret_cnt_q <= ret_cnt_q + len_t'(1);
                    end
                    if (rd_finish_o) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // address, command and write data
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_250m_i) begin
        if (start_wr) begin
            len_q      <= wr_len_i;
            cur_addr_q <= wr_addr_i;
            app_cmd_o  <= APP_CMD_WRITE;
        end else if (start_rd) begin
            len_q      <= rd_len_i;
            app_addr_o <= rd_addr_i;
            cur_addr_q <= rd_addr_i + ADDR_STEP;
            app_cmd_o  <= APP_CMD_READ;
        end
        if (state_q == ST_WRITE && fetch_q) begin
            app_addr_o     <= cur_addr_q;
            app_wdf_data_o <= wr_data_i;   // channel holds it this cycle
        end
        if (beat_done) begin
            cur_addr_q <= cur_addr_q + ADDR_STEP;
        end
        if (rd_issue) begin
            app_addr_o <= cur_addr_q;
            cur_addr_q <= cur_addr_q + ADDR_STEP;
        end
    end

    assign wr_data_req_o = data_req_q;
    assign wr_finish_o   = wr_fin_q;

    // read return passes straight on, rd_arbiter adds the register
    assign rd_data_valid_o = (state_q == ST_READ) && app_rd_data_valid_i;
    assign rd_data_o       = app_rd_data_i;
    assign rd_finish_o     = rd_data_valid_o && (ret_cnt_q == len_q - len_t'(1));

endmodule

// File: design/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                   clk_250m_i,
    input  logic                   rst_i,
    input  logic                   init_calib_complete_i,
    // write channels
    input  logic                   wr_req_i        [mem_ctrl_pkg::N_WR_CH],
    input  mem_ctrl_pkg::addr_t    wr_addr_i       [mem_ctrl_pkg::N_WR_CH],
    input  mem_ctrl_pkg::len_t     wr_len_i        [mem_ctrl_pkg::N_WR_CH],
    input  mem_ctrl_pkg::data_t    wr_data_i       [mem_ctrl_pkg::N_WR_CH],
    output logic                   wr_data_req_o   [mem_ctrl_pkg::N_WR_CH],
    output logic                   wr_finish_o     [mem_ctrl_pkg::N_WR_CH],
    // read channels
    input  logic                   rd_req_i        [mem_ctrl_pkg::N_RD_CH],
    input  mem_ctrl_pkg::addr_t    rd_addr_i       [mem_ctrl_pkg::N_RD_CH],
    input  mem_ctrl_pkg::len_t     rd_len_i        [mem_ctrl_pkg::N_RD_CH],
    output logic                   rd_data_valid_o [mem_ctrl_pkg::N_RD_CH],
    output mem_ctrl_pkg::data_t    rd_data_o       [mem_ctrl_pkg::N_RD_CH],
    output logic                   rd_finish_o     [mem_ctrl_pkg::N_RD_CH],
    // application port
    output logic                   app_en_o,
    output mem_ctrl_pkg::app_cmd_e app_cmd_o,
    output mem_ctrl_pkg::addr_t    app_addr_o,
    input  logic                   app_rdy_i,
    output logic                   app_wdf_wren_o,
    output mem_ctrl_pkg::data_t    app_wdf_data_o,
    input  logic                   app_wdf_rdy_i,
    input  logic                   app_rd_data_valid_i,
    input  mem_ctrl_pkg::data_t    app_rd_data_i
);

    import mem_ctrl_pkg::*;

    ////////////////////////////////////////////////////////////
    // arbiter to engine links
    ////////////////////////////////////////////////////////////
    logic  wr_req;
    addr_t wr_addr;
    len_t  wr_len;
    data_t wr_data;
    logic  wr_data_req;
    logic  wr_finish;

    logic  rd_req;
    addr_t rd_addr;
    len_t  rd_len;
    logic  rd_data_valid;
    data_t rd_data;
    logic  rd_finish;

    wr_arbiter i_wr_arbiter (
        .clk_250m_i    (clk_250m_i),
        .rst_i         (rst_i),
        .ch_req_i      (wr_req_i),
        .ch_addr_i     (wr_addr_i),
        .ch_len_i      (wr_len_i),
        .ch_data_i     (wr_data_i),
        .ch_data_req_o (wr_data_req_o),
        .ch_finish_o   (wr_finish_o),
        .wr_req_o      (wr_req),
        .wr_addr_o     (wr_addr),
        .wr_len_o      (wr_len),
        .wr_data_o     (wr_data),
        .wr_data_req_i (wr_data_req),
        .wr_finish_i   (wr_finish)
    );

    burst_engine i_burst_engine (
        .clk_250m_i            (clk_250m_i),
        .rst_i                 (rst_i),
        .init_calib_complete_i (init_calib_complete_i),
        .wr_req_i              (wr_req),
        .wr_addr_i             (wr_addr),
        .wr_len_i              (wr_len),
        .wr_data_i             (wr_data),
        .wr_data_req_o         (wr_data_req),
        .wr_finish_o           (wr_finish),
        .rd_req_i              (rd_req),
        .rd_addr_i             (rd_addr),
        .rd_len_i              (rd_len),
        .rd_data_valid_o       (rd_data_valid),
        .rd_data_o             (rd_data),
        .rd_finish_o           (rd_finish),
        .app_en_o              (app_en_o),
        .app_cmd_o             (app_cmd_o),
        .app_addr_o            (app_addr_o),
        .app_rdy_i             (app_rdy_i),
        .app_wdf_wren_o        (app_wdf_wren_o),
        .app_wdf_data_o        (app_wdf_data_o),
        .app_wdf_rdy_i         (app_wdf_rdy_i),
        .app_rd_data_valid_i   (app_rd_data_valid_i),
        .app_rd_data_i         (app_rd_data_i)
    );

    rd_arbiter i_rd_arbiter (
        .clk_250m_i      (clk_250m_i),
        .rst_i           (rst_i),
        .ch_req_i        (rd_req_i),
        .ch_addr_i       (rd_addr_i),
        .ch_len_i        (rd_len_i),
        .ch_data_valid_o (rd_data_valid_o),
        .ch_data_o       (rd_data_o),
        .ch_finish_o     (rd_finish_o),
        .rd_req_o        (rd_req),
        .rd_addr_o       (rd_addr),
        .rd_len_o        (rd_len),
        .rd_data_valid_i (rd_data_valid),
        .rd_data_i       (rd_data),
        .rd_finish_i     (rd_finish)
    );

endmodule

// File: tests/mem_ctrl_assertions.sv
`timescale 1ns/1ps

module mem_ctrl_assertions (
    input logic                clk_250m_i,
    input logic                rst_i,
    input logic                init_calib_complete_i,
    input logic                app_en_o,
    input mem_ctrl_pkg::addr_t app_addr_o,
    input logic                app_rdy_i,
    input logic                wr_finish_o,
    input logic                rd_finish_o
);

    a_calib: assert property (@(posedge clk_250m_i) disable iff (rst_i)
        app_en_o |-> init_calib_complete_i)
        else $error("app_en before calibration");

    // command held while the core is not ready
    a_cmd_hold: assert property (@(posedge clk_250m_i) disable iff (rst_i)
        app_en_o && !app_rdy_i |=> app_en_o && $stable(app_addr_o))
        else $error("command dropped or changed under back-pressure");

    a_wr_fin: assert property (@(posedge clk_250m_i) disable iff (rst_i)
        wr_finish_o |=> !wr_finish_o)
        else $error("write finish longer than one cycle");

    a_rd_fin: assert property (@(posedge clk_250m_i) disable iff (rst_i)
        rd_finish_o |=> !rd_finish_o)
        else $error("read finish longer than one cycle");

endmodule

bind burst_engine mem_ctrl_assertions i_mem_ctrl_assertions (
    .clk_250m_i            (clk_250m_i),
    .rst_i                 (rst_i),
    .init_calib_complete_i (init_calib_complete_i),
    .app_en_o              (app_en_o),
    .app_addr_o            (app_addr_o),
    .app_rdy_i             (app_rdy_i),
    .wr_finish_o           (wr_finish_o),
    .rd_finish_o           (rd_finish_o)
);

// File: tests/tb_mem_ctrl.sv
`timescale 1ns/1ps

module tb_mem_ctrl;

    import mem_ctrl_pkg::*;

    // beats over all bursts below set the watchdog
    localparam int TOTAL_BEATS = 16 + 16 + 37 + 16 + 3 * 24 + 16 + 20 + 8;

    logic     clk_250m_i;
    logic     rst_i;
    logic     calib;
    logic     wr_req [N_WR_CH];
    addr_t    wr_addr [N_WR_CH];
    len_t     wr_len [N_WR_CH];
    data_t    wr_data [N_WR_CH];
    logic     wr_data_req [N_WR_CH];
    logic     wr_finish [N_WR_CH];
    logic     rd_req [N_RD_CH];
    addr_t    rd_addr [N_RD_CH];
    len_t     rd_len [N_RD_CH];
    logic     rd_valid [N_RD_CH];
    data_t    rd_data [N_RD_CH];
    logic     rd_finish [N_RD_CH];
    logic     app_en;
    app_cmd_e app_cmd;
    addr_t    app_addr;
    logic     app_rdy;
    logic     app_wdf_wren;
    data_t    app_wdf_data;
    logic     app_wdf_rdy;
    logic     app_rd_valid;
    data_t    app_rd_data;

    data_t mem [addr_t];            // memory behind the app port
    int    shadow_ch [addr_t];      // last writer of each address
    addr_t shadow_base [addr_t];
    addr_t wq_addr [$];
    data_t wq_data [$];
    addr_t wr_cmd_log [$];          // accepted write command addresses
    addr_t rd_pend_addr [$];
    int    rd_pend_due [$];
    int    fin_order [$];
    addr_t rd_base [N_RD_CH];
    int    rd_beat [N_RD_CH];
    int    cyc;
    logic  stall_en;
    int    err_cnt;
    int    test_cnt;
    int    test_fail;

    mem_ctrl i_mem_ctrl (
        .clk_250m_i            (clk_250m_i),
        .rst_i                 (rst_i),
        .init_calib_complete_i (calib),
        .wr_req_i              (wr_req),
        .wr_addr_i             (wr_addr),
        .wr_len_i              (wr_len),
        .wr_data_i             (wr_data),
        .wr_data_req_o         (wr_data_req),
        .wr_finish_o           (wr_finish),
        .rd_req_i              (rd_req),
        .rd_addr_i             (rd_addr),
        .rd_len_i              (rd_len),
        .rd_data_valid_o       (rd_valid),
        .rd_data_o             (rd_data),
        .rd_finish_o           (rd_finish),
        .app_en_o              (app_en),
        .app_cmd_o             (app_cmd),
        .app_addr_o            (app_addr),
        .app_rdy_i             (app_rdy),
        .app_wdf_wren_o        (app_wdf_wren),
        .app_wdf_data_o        (app_wdf_data),
        .app_wdf_rdy_i         (app_wdf_rdy),
        .app_rd_data_valid_i   (app_rd_valid),
        .app_rd_data_i         (app_rd_data)
    );

    initial begin
        clk_250m_i = 1'b0;
        forever #2 clk_250m_i = ~clk_250m_i;
    end

    ////////////////////////////////////////////////////////////
    // reference and compare tasks
    ////////////////////////////////////////////////////////////
    function automatic data_t ref_word(int ch, addr_t base, int k);
        logic [7:0]  tag;
        logic [23:0] mix;
        tag = 8'hc0 + 8'(ch);
        mix = (24'(k) * 24'h00_9e37) ^ 24'h5a_5a5a;
        return {tag, 2'b00, base, mix};
    endfunction

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(string name, len_t got, len_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory model driven on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk_250m_i) begin
        cyc++;
        app_rdy     = stall_en ? ($urandom % 4 != 0) : 1'b1;
        app_wdf_rdy = stall_en ? ($urandom % 3 != 0) : 1'b1;
        if (app_en && app_rdy) begin    // taken at the next rising edge
            if (app_cmd == APP_CMD_WRITE) begin
                wq_addr.push_back(app_addr);
                wr_cmd_log.push_back(app_addr);
            end else begin
                rd_pend_addr.push_back(app_addr);
                rd_pend_due.push_back(cyc + 2 + int'($urandom % 5));
            end
        end
        if (app_wdf_wren && app_wdf_rdy) begin
            wq_data.push_back(app_wdf_data);
        end
        while (wq_addr.size() > 0 && wq_data.size() > 0) begin
            mem[wq_addr.pop_front()] = wq_data.pop_front();
        end
        if (rd_pend_due.size() > 0 && rd_pend_due[0] <= cyc) begin
            void'(rd_pend_due.pop_front());
            app_rd_valid = 1'b1;
            app_rd_data  = mem.exists(rd_pend_addr[0]) ? mem[rd_pend_addr[0]] : '0;
            void'(rd_pend_addr.pop_front());
        end else begin
            app_rd_valid = 1'b0;
        end
    end

    // read beats against the shadow
    always @(negedge clk_250m_i) begin
        addr_t a;
        for (int i = 0; i < N_RD_CH; i++) begin
            if (rd_valid[i]) begin
                a = rd_base[i] + addr_t'(rd_beat[i]) * ADDR_STEP;
                if (!shadow_ch.exists(a)) begin
                    $display("read channel %0d returned data for unwritten address %h", i, a);
                    err_cnt++;
                end else begin
                    check_data("rd_data_o", rd_data[i], ref_word(shadow_ch[a],
                               shadow_base[a], int'((a - shadow_base[a]) / ADDR_STEP)));
                end
                rd_beat[i]++;
            end
            if (rd_finish[i]) fin_order.push_back(i);
        end
    end

    ////////////////////////////////////////////////////////////
    // channel drivers
    ////////////////////////////////////////////////////////////
    task automatic wr_burst(int ch, addr_t base, int len);
        int   k;
        logic done;
        k    = 0;
        done = 1'b0;
        @(negedge clk_250m_i);
        for (int i = 0; i < len; i++) begin
            shadow_ch[base + addr_t'(i) * ADDR_STEP]   = ch;
            shadow_base[base + addr_t'(i) * ADDR_STEP] = base;
        end
        wr_req[ch]  = 1'b1;
        wr_addr[ch] = base;
        wr_len[ch]  = len_t'(len);
        while (!done) begin
            @(negedge clk_250m_i);
            if (wr_data_req[ch]) begin
                wr_data[ch] = ref_word(ch, base, k);   // held until next pulse
                k++;
            end
            done = wr_finish[ch];
        end
        wr_req[ch] = 1'b0;
        check_count("wr_data_req_o beats", len_t'(k), len_t'(len));
        check_count("app_en_o write commands", len_t'(wr_cmd_log.size()), len_t'(len));
        for (int i = 0; i < wr_cmd_log.size(); i++) begin
            check_addr("app_addr_o", wr_cmd_log[i], base + addr_t'(i) * ADDR_STEP);
        end
        wr_cmd_log.delete();
    endtask

    task automatic rd_burst(int ch, addr_t base, int len);
        @(negedge clk_250m_i);
        rd_base[ch] = base;
        rd_beat[ch] = 0;
        rd_req[ch]  = 1'b1;
        rd_addr[ch] = base;
        rd_len[ch]  = len_t'(len);
        do @(negedge clk_250m_i); while (!rd_finish[ch]);
        rd_req[ch] = 1'b0;
        @(negedge clk_250m_i);    // let the compare process count the last beat
        check_count("rd_data_valid_o beats", len_t'(rd_beat[ch]), len_t'(len));
    endtask

    task automatic do_reset(logic cal);
        rst_i = 1'b1;
        calib = cal;
        for (int i = 0; i < N_WR_CH; i++) wr_req[i] = 1'b0;
        for (int i = 0; i < N_RD_CH; i++) rd_req[i] = 1'b0;
        repeat (4) @(posedge clk_250m_i);
        @(negedge clk_250m_i);
        rst_i = 1'b0;
    endtask

    task automatic end_test(string name, int err_before);
        test_cnt++;
        if (err_cnt != err_before) test_fail++;
        $display("test %0d %s: %s", test_cnt, name, err_cnt == err_before ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int e;
        void'($urandom(32'h04f0_8e4a));
        rst_i = 1'b1;
        calib = 1'b0;
        stall_en = 1'b0;
        app_rdy = 1'b1;
        app_wdf_rdy = 1'b1;
        app_rd_valid = 1'b0;
        app_rd_data = '0;
        cyc = 0;
        err_cnt = 0;
        test_cnt = 0;
        test_fail = 0;
        for (int i = 0; i < N_WR_CH; i++) begin
            wr_req[i] = 1'b0;
            wr_addr[i] = '0;
            wr_len[i] = '0;
            wr_data[i] = '0;
        end
        for (int i = 0; i < N_RD_CH; i++) begin
            rd_req[i] = 1'b0;
            rd_addr[i] = '0;
            rd_len[i] = '0;
            rd_base[i] = '0;
            rd_beat[i] = 0;
        end

        // nothing may move while calibration is low
        do_reset(1'b0);
        e = err_cnt;
        wr_req[0] = 1'b1;
        wr_len[0] = len_t'(4);
        rd_req[0] = 1'b1;
        rd_len[0] = len_t'(4);
        repeat (50) begin
            @(negedge clk_250m_i);
            if (app_en || app_wdf_wren || wr_data_req[0] || wr_finish[0]
                || rd_valid[0] || rd_finish[0]) begin
                $display("activity on the app port or a channel before calibration");
                err_cnt++;
            end
        end
        end_test("idle before calibration", e);

        do_reset(1'b1);
        e = err_cnt;
        wr_burst(0, addr_t'(30'h1000), 16);
        rd_burst(0, addr_t'(30'h1000), 16);
        end_test("single channel round trip", e);

        e = err_cnt;
        wr_burst(1, addr_t'(30'h4000), 37);
        end_test("command addresses", e);

        do_reset(1'b1);
        e = err_cnt;
        fin_order.delete();
        fork
            rd_burst(0, addr_t'(30'h1000), 4);
            rd_burst(1, addr_t'(30'h1020), 4);
            rd_burst(2, addr_t'(30'h1040), 4);
            rd_burst(3, addr_t'(30'h1060), 4);
        join
        check_count("rd_finish_o count", len_t'(fin_order.size()), len_t'(4));
        for (int i = 0; i < fin_order.size(); i++) begin
            check_count("rd_finish_o order", len_t'(fin_order[i]), len_t'(i));
        end
        end_test("read round-robin order", e);

        e = err_cnt;
        stall_en = 1'b1;
        fork
            wr_burst(0, addr_t'(30'h8000), 24);
            wr_burst(1, addr_t'(30'h9000), 24);
            wr_burst(2, addr_t'(30'ha000), 24);
            rd_burst(1, addr_t'(30'h1000), 16);
            rd_burst(2, addr_t'(30'h4000), 20);
            rd_burst(3, addr_t'(30'h1040), 8);
        join
        stall_en = 1'b0;
        end_test("stalls and mixed traffic", e);

        $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_BEATS * 20 + 2000) @(posedge clk_250m_i);
        $display("timeout, the bursts did not all finish");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: sources.f
design/mem_ctrl_pkg.sv
design/wr_arbiter.sv
design/rd_arbiter.sv
design/burst_engine.sv
design/mem_ctrl.sv
tests/mem_ctrl_assertions.sv
tests/tb_mem_ctrl.sv

// File: Makefile
SRCS := $(wildcard design/*.sv tests/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_mem_ctrl
	out="$$(./obj_dir/Vtb_mem_ctrl)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

obj_dir/Vtb_mem_ctrl: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mem_ctrl -f sources.f

clean:
	rm -rf obj_dir
